//--- build.f
+incdir+source
source/bus_pkg.sv
source/bus_arbiter_fsm.sv
source/clint_timer.sv
source/read_steer.sv
source/write_align.sv
source/bus_top.sv
sim/bus_assertions.sv
sim/bus_tb.sv

//--- build.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module bus_tb -f build.f -o bus_sim
./obj_dir/bus_sim | tee sim.log

if grep -q "Regression failed" sim.log; then
  exit 1
fi
exit 0

//--- sim/bus_tb.sv
`include "bus_defines.svh"

module bus_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import bus_pkg::*;

  localparam word_t FILL_KEY = 32'hA5A5_0000;

  logic      clk = 1'b0;
  logic      rst = 1'b1;
  rd_req_t   ifu_req_i;
  logic      ifu_valid_i;
  rd_req_t   lsu_rd_i;
  logic      lsu_rvalid_i;
  wr_req_t   lsu_wr_i;
  logic      lsu_wvalid_i;
  logic      arready_i = 1'b0;
  axi_data_t rdata_i = '0;
  logic      rvalid_i = 1'b0;
  logic      awready_i = 1'b0;
  logic      wready_i = 1'b0;
  logic      bvalid_i = 1'b0;
  word_t     ifu_rdata_o;
  logic      ifu_rvalid_o;
  word_t     lsu_rdata_o;
  logic      lsu_rvalid_o;
  logic      lsu_wdone_o;
  ar_chan_t  ar_o;
  logic      arvalid_o;
  aw_chan_t  aw_o;
  logic      awvalid_o;
  w_chan_t   w_o;
  logic      wvalid_o;

  integer    seed = 32'h124b;
  int        errors = 0;
  axi_data_t mem [32];
  word_t     ref_mem [64];

  // slave side bookkeeping
  logic      ar_fire = 1'b0;
  logic      aw_fire = 1'b0;
  logic      w_fire = 1'b0;
  ar_chan_t  ar_q;
  aw_chan_t  aw_q;
  w_chan_t   w_q;
  ar_chan_t  last_ar;
  int        rd_wait = 0;
  logic      rd_busy = 1'b0;
  logic      aw_got = 1'b0;
  logic      w_got = 1'b0;
  aw_chan_t  last_aw;
  w_chan_t   last_w;
  logic [31:0] rnd;
  int        ar_count = 0;

  bus_top UUT (.*);

  always #4 clk = ~clk;

  always @(posedge clk)
  begin
    ar_fire <= arvalid_o & arready_i;
    aw_fire <= awvalid_o & awready_i;
    w_fire  <= wvalid_o & wready_i;
    ar_q    <= ar_o;
    aw_q    <= aw_o;
    w_q     <= w_o;
    if (arvalid_o)
      ar_count <= ar_count + 1;
  end

  // memory slave with random ready stalls and read latency
  always @(negedge clk)
  begin
    rvalid_i = 1'b0;
    bvalid_i = 1'b0;
    if (rst)
    begin
      rd_busy = 1'b0;
      aw_got = 1'b0;
      w_got = 1'b0;
      arready_i = 1'b0;
      awready_i = 1'b0;
      wready_i = 1'b0;
    end
    else
    begin
      if (ar_fire)
      begin
        rd_busy = 1'b1;
        last_ar = ar_q;
        rd_wait = $random(seed) & 3;
      end
      if (rd_busy)
      begin
        if (rd_wait == 0)
        begin
          rvalid_i = 1'b1;
          rdata_i = mem[last_ar.addr[7:3]];
          rd_busy = 1'b0;
        end
        else
          rd_wait--;
      end
      if (aw_fire)
      begin
        aw_got = 1'b1;
        last_aw = aw_q;
      end
      if (w_fire)
      begin
        w_got = 1'b1;
        last_w = w_q;
      end
      if (aw_got && w_got)
      begin
        for (int b = 0; b < 8; b++)
          if (last_w.strb[b])
            mem[last_aw.addr[7:3]][b*8 +: 8] = last_w.data[b*8 +: 8];
        bvalid_i = 1'b1;
        aw_got = 1'b0;
        w_got = 1'b0;
      end
      rnd = $random(seed);
      arready_i = !rd_busy & rnd[0];
      awready_i = !aw_got & rnd[1];
      wready_i = !w_got & rnd[2];
    end
  end

  task end_run();
    $display("errors: %0d", errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  endtask

  task automatic check_value(input string test, input word_t expv, input word_t actv);
    if (expv !== actv)
    begin
      errors++;
      $display("mismatch %s expected %h actual %h", test, expv, actv);
    end
  endtask

  // sel is 0 for fetch, 1 for load, 2 for store done
  task automatic wait_resp(input int sel, input string what, output word_t data);
    int   cycles;
    logic seen;
    cycles = 0;
    seen = 1'b0;
    data = '0;
    while (!seen && cycles < 200)
    begin
      @(posedge clk);
      cycles++;
      case (sel)
        0:
        begin
          seen = ifu_rvalid_o;
          data = ifu_rdata_o;
        end
        1:
        begin
          seen = lsu_rvalid_o;
          data = lsu_rdata_o;
        end
        default:
          seen = lsu_wdone_o;
      endcase
    end
    if (!seen)
    begin
      errors++;
      $display("timeout: no %s within 200 cycles", what);
      end_run();
    end
  endtask

  task automatic do_fetch(input addr_t addr, output word_t data);
    @(negedge clk);
    ifu_req_i.addr = addr;
    ifu_req_i.mask = 4'hf;
    ifu_valid_i = 1'b1;
    wait_resp(0, "fetch response", data);
    @(negedge clk);
    ifu_valid_i = 1'b0;
  endtask

  task automatic do_load(input addr_t addr, input logic [3:0] mask, output word_t data);
    @(negedge clk);
    lsu_rd_i.addr = addr;
    lsu_rd_i.mask = mask;
    lsu_rvalid_i = 1'b1;
    wait_resp(1, "load response", data);
    @(negedge clk);
    lsu_rvalid_i = 1'b0;
  endtask

  task automatic do_store(input addr_t addr, input word_t data, input logic [3:0] mask);
    word_t unused;
    @(negedge clk);
    lsu_wr_i.addr = addr;
    lsu_wr_i.data = data;
    lsu_wr_i.mask = mask;
    lsu_wvalid_i = 1'b1;
    wait_resp(2, "store done", unused);
    @(negedge clk);
    lsu_wvalid_i = 1'b0;
  endtask

  task automatic test_reset();
    @(posedge clk);
    check_value("reset arvalid", 0, 32'(arvalid_o));
    check_value("reset awvalid", 0, 32'(awvalid_o));
    check_value("reset wvalid", 0, 32'(wvalid_o));
    check_value("reset ifu_rvalid", 0, 32'(ifu_rvalid_o));
    check_value("reset lsu_rvalid", 0, 32'(lsu_rvalid_o));
    check_value("reset wdone", 0, 32'(lsu_wdone_o));
    check_value("reset state", 1, 32'(UUT.state == IF_A));
  endtask

  task automatic test_fetch();
    word_t got;
    for (int i = 0; i < 16; i++)
    begin
      do_fetch(addr_t'(i * 4), got);
      check_value("fetch", ref_mem[i], got);
      check_value("fetch size", 2, 32'(last_ar.size));
    end
  endtask

  task automatic test_store_load();
    logic [3:0] mask;
    logic [3:0] sh;
    int         off;
    addr_t      base;
    addr_t      addr;
    word_t      d;
    word_t      sd;
    word_t      got;
    logic [7:0] exp_strb;
    size_t      exp_size;
    for (int i = 0; i < 8; i++)
    begin
      mask = (i < 4) ? 4'h1 : (i < 6) ? 4'h3 : 4'hf;
      off = (i < 4) ? i : (i == 5) ? 2 : 0;
      base = (i == 7) ? 32'h44 : 32'h40;
      addr = base | addr_t'(off);
      d = $random(seed);
      sd = d << (off * 8);
      sh = mask << off;
      exp_strb = base[2] ? {sh, 4'h0} : {4'h0, sh};
      // byte 0, halfword 1, word 2
      exp_size = (mask == 4'h1) ? 3'd0 : (mask == 4'h3) ? 3'd1 : 3'd2;
      for (int b = 0; b < 4; b++)
        if (sh[b])
          ref_mem[addr[7:2]][b*8 +: 8] = sd[b*8 +: 8];
      do_store(addr, d, mask);
      check_value("store strobe", 32'(exp_strb), 32'(last_w.strb));
      check_value("store data low", sd, last_w.data[31:0]);
      check_value("store data high", sd, last_w.data[63:32]);
      check_value("store size", 32'(exp_size), 32'(last_aw.size));
      do_load(base, mask, got);
      check_value("load size", 32'(exp_size), 32'(last_ar.size));
      check_value("load after store", ref_mem[base[7:2]], got);
    end
  endtask

  task automatic test_simultaneous();
    word_t f_data;
    word_t l_data;
    int    cycles;
    logic  f_seen;
    logic  l_seen;
    logic  fetch_first;
    @(negedge clk);
    ifu_req_i.addr = 32'h10;
    ifu_req_i.mask = 4'hf;
    lsu_rd_i.addr = 32'h48;
    lsu_rd_i.mask = 4'hf;
    ifu_valid_i = 1'b1;
    lsu_rvalid_i = 1'b1;
    cycles = 0;
    f_seen = 1'b0;
    l_seen = 1'b0;
    fetch_first = 1'b0;
    while (!(f_seen && l_seen) && cycles < 200)
    begin
      @(posedge clk);
      cycles++;
      if (ifu_rvalid_o && lsu_rvalid_o)
      begin
        errors++;
        $display("fetch and load responses arrived in the same cycle");
      end
      if (ifu_rvalid_o)
      begin
        f_seen = 1'b1;
        f_data = ifu_rdata_o;
        fetch_first = !l_seen;
      end
      if (lsu_rvalid_o)
      begin
        l_seen = 1'b1;
        l_data = lsu_rdata_o;
      end
      @(negedge clk);
      if (f_seen)
        ifu_valid_i = 1'b0;
      if (l_seen)
        lsu_rvalid_i = 1'b0;
    end
    if (!(f_seen && l_seen))
    begin
      errors++;
      $display("timeout: no %s within 200 cycles",
               f_seen ? "load response" : "fetch response");
      end_run();
    end
    else
    begin
      check_value("simultaneous order", 1, 32'(fetch_first));
      check_value("simultaneous fetch", ref_mem[4], f_data);
      check_value("simultaneous load", ref_mem[18], l_data);
    end
  endtask

  task automatic test_timer_low();
    word_t t0;
    word_t t1;
    int    ar_before;
    ar_before = ar_count;
    do_load(`BUS_RTC_ADDR, 4'hf, t0);
    repeat (10) @(negedge clk);
    do_load(`BUS_RTC_ADDR, 4'hf, t1);
    check_value("timer low increasing", 1, 32'(t1 > t0));
    check_value("timer bus quiet", ar_before, ar_count);
  endtask

  task automatic test_timer_high();
    word_t got;
    do_load(`BUS_RTC_ADDR_UP, 4'hf, got);
    check_value("timer high", 0, got);
  endtask

  initial
  begin
    ifu_req_i = '0;
    ifu_valid_i = 1'b0;
    lsu_rd_i = '0;
    lsu_rvalid_i = 1'b0;
    lsu_wr_i = '0;
    lsu_wvalid_i = 1'b0;
    // each beat holds two words of address xor key
    for (int i = 0; i < 32; i++)
      mem[i] = {word_t'(i * 8 + 4) ^ FILL_KEY, word_t'(i * 8) ^ FILL_KEY};
    for (int j = 0; j < 64; j++)
      ref_mem[j] = word_t'(j * 4) ^ FILL_KEY;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_reset();
    test_fetch();
    test_store_load();
    test_simultaneous();
    test_timer_low();
    test_timer_high();
    end_run();
  end

endmodule

//--- sim/bus_assertions.sv
module bus_assertions (
  input logic              clk,
  input logic              rst,
  input logic              arvalid_o,
  input logic              arready_i,
  input logic              awvalid_o,
  input logic              awready_i,
  input logic              wvalid_o,
  input logic              wready_i,
  input logic              lsu_wvalid_i,
  input bus_pkg::ar_chan_t ar_o,
  input bus_pkg::aw_chan_t aw_o,
  input bus_pkg::w_chan_t  w_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // a stalled channel keeps valid and payload
  ar_hold: assert property (@(posedge clk) disable iff (rst)
    arvalid_o && !arready_i |=> arvalid_o && $stable(ar_o))
    else $error("ar payload or valid changed during a stall");

  aw_hold: assert property (@(posedge clk) disable iff (rst)
    awvalid_o && !awready_i |=> awvalid_o && $stable(aw_o))
    else $error("aw payload or valid changed during a stall");

  w_hold: assert property (@(posedge clk) disable iff (rst)
    wvalid_o && !wready_i |=> wvalid_o && $stable(w_o))
    else $error("w payload or valid changed during a stall");

  reset_quiet: assert property (@(posedge clk)
    rst |-> !arvalid_o && !awvalid_o && !wvalid_o)
    else $error("bus valid high in reset");

  store_only: assert property (@(posedge clk) disable iff (rst)
    (awvalid_o || wvalid_o) |-> lsu_wvalid_i)
    else $error("write channel valid without a store request");

endmodule

bind bus_top bus_assertions u_assertions (.*);

//--- source/bus_top.sv
module bus_top (
  input  logic               clk,
  input  logic               rst,
  input  bus_pkg::rd_req_t   ifu_req_i,
  input  logic               ifu_valid_i,
  input  bus_pkg::rd_req_t   lsu_rd_i,
  input  logic               lsu_rvalid_i,
  input  bus_pkg::wr_req_t   lsu_wr_i,
  input  logic               lsu_wvalid_i,
  input  logic               arready_i,
  input  bus_pkg::axi_data_t rdata_i,
  input  logic               rvalid_i,
  input  logic               awready_i,
  input  logic               wready_i,
  input  logic               bvalid_i,
  output bus_pkg::word_t     ifu_rdata_o,
  output logic               ifu_rvalid_o,
  output bus_pkg::word_t     lsu_rdata_o,
  output logic               lsu_rvalid_o,
  output logic               lsu_wdone_o,
  output bus_pkg::ar_chan_t  ar_o,
  output logic               arvalid_o,
  output bus_pkg::aw_chan_t  aw_o,
  output logic               awvalid_o,
  output bus_pkg::w_chan_t   w_o,
  output logic               wvalid_o
);
  import bus_pkg::*;

  arb_state_t state;
  logic       lsu_local;
  logic       clint_rd_en;
  word_t      clint_rdata;
  logic       clint_rvalid;

  // store completes with the write response
  assign lsu_wdone_o = bvalid_i;

  bus_arbiter_fsm u_fsm (
    .clk            (clk),
    .rst            (rst),
    .ifu_valid_i    (ifu_valid_i),
    .lsu_rvalid_i   (lsu_rvalid_i),
    .lsu_wvalid_i   (lsu_wvalid_i),
    .lsu_local_i    (lsu_local),
    .arready_i      (arready_i),
    .awready_i      (awready_i),
    .wready_i       (wready_i),
    .rvalid_i       (rvalid_i),
    .bvalid_i       (bvalid_i),
    .clint_rvalid_i (clint_rvalid),
    .state_o        (state),
    .aw_pending_o   (awvalid_o),
    .w_pending_o    (wvalid_o),
    .arvalid_o      (arvalid_o)
  );

  clint_timer u_clint (
    .clk      (clk),
    .rst      (rst),
    .rd_en_i  (clint_rd_en),
    .addr_i   (lsu_rd_i.addr),
    .rdata_o  (clint_rdata),
    .rvalid_o (clint_rvalid)
  );

  read_steer u_read (
    .ifu_req_i      (ifu_req_i),
    .lsu_rd_i       (lsu_rd_i),
    .state_i        (state),
    .lsu_rvalid_i   (lsu_rvalid_i),
    .rvalid_i       (rvalid_i),
    .rdata_i        (rdata_i),
    .clint_rdata_i  (clint_rdata),
    .clint_rvalid_i (clint_rvalid),
    .ar_o           (ar_o),
    .lsu_local_o    (lsu_local),
    .clint_rd_en_o  (clint_rd_en),
    .ifu_rdata_o    (ifu_rdata_o),
    .ifu_rvalid_o   (ifu_rvalid_o),
    .lsu_rdata_o    (lsu_rdata_o),
    .lsu_rvalid_o   (lsu_rvalid_o)
  );

  write_align u_write (
    .wr_i (lsu_wr_i),
    .aw_o (aw_o),
    .w_o  (w_o)
  );

endmodule

//--- source/write_align.sv
module write_align (
  input  bus_pkg::wr_req_t wr_i,
  output bus_pkg::aw_chan_t aw_o,
  output bus_pkg::w_chan_t  w_o
);
  import bus_pkg::*;

  logic [1:0] off;
  word_t      lane_data;
  logic [3:0] lane_strb;

  assign off = wr_i.addr[1:0];

  // move the store onto its byte lanes
  assign lane_data = wr_i.data << {off, 3'b000};
  assign lane_strb = wr_i.mask << off;

  assign aw_o.addr = wr_i.addr;
  assign aw_o.size = size_from_mask(wr_i.mask);

  // same word in both halves
  // strobes pick the live one
  assign w_o.data = {lane_data, lane_data};
  assign w_o.strb = wr_i.addr[2] ? {lane_strb, 4'b0000} : {4'b0000, lane_strb};

endmodule

//--- source/read_steer.sv
`include "bus_defines.svh"

module read_steer (
  input  bus_pkg::rd_req_t    ifu_req_i,
  input  bus_pkg::rd_req_t    lsu_rd_i,
  input  bus_pkg::arb_state_t state_i,
  input  logic                lsu_rvalid_i,
  input  logic                rvalid_i,
  input  bus_pkg::axi_data_t  rdata_i,
  input  bus_pkg::word_t      clint_rdata_i,
  input  logic                clint_rvalid_i,
  output bus_pkg::ar_chan_t   ar_o,
  output logic                lsu_local_o,
  output logic                clint_rd_en_o,
  output bus_pkg::word_t      ifu_rdata_o,
  output logic                ifu_rvalid_o,
  output bus_pkg::word_t      lsu_rdata_o,
  output logic                lsu_rvalid_o
);
  import bus_pkg::*;

  logic  if_phase;
  word_t bus_word;

  assign lsu_local_o = (lsu_rd_i.addr == `BUS_RTC_ADDR) |
                       (lsu_rd_i.addr == `BUS_RTC_ADDR_UP);

  assign if_phase = (state_i == IF_A) | (state_i == IF_D);

  // fetch is always a full word
  assign ar_o.addr = if_phase ? ifu_req_i.addr : lsu_rd_i.addr;
  assign ar_o.size = if_phase ? 3'd2 : size_from_mask(lsu_rd_i.mask);

  // address is still held by the requester during the data phase
  assign bus_word = ar_o.addr[2] ? rdata_i[63:32] : rdata_i[31:0];

  assign clint_rd_en_o = (state_i == LS_A) & lsu_rvalid_i & lsu_local_o;

  assign ifu_rdata_o  = bus_word;
  assign ifu_rvalid_o = (state_i == IF_D) & rvalid_i;

  assign lsu_rdata_o  = lsu_local_o ? clint_rdata_i : bus_word;
  assign lsu_rvalid_o = (state_i == LS_D_R) & lsu_rvalid_i &
                        (lsu_local_o ? clint_rvalid_i : rvalid_i);

endmodule

//--- source/clint_timer.sv
`include "bus_defines.svh"

module clint_timer (
  input  logic           clk,
  input  logic           rst,
  input  logic           rd_en_i,
  input  bus_pkg::addr_t addr_i,
  output bus_pkg::word_t rdata_o,
  output logic           rvalid_o
);
  import bus_pkg::*;

  logic [63:0] mtime;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime    <= 64'd0;
      rvalid_o <= 1'b0;
    end
    else
    begin
      mtime    <= mtime + 64'd1;
      rvalid_o <= rd_en_i;
    end
  end

  // selected half of mtime
  always_ff @(posedge clk)
  begin
    if (rd_en_i)
      rdata_o <= (addr_i == `BUS_RTC_ADDR_UP) ? mtime[63:32] : mtime[31:0];
  end

endmodule

//--- source/bus_arbiter_fsm.sv
module bus_arbiter_fsm (
  input  logic                clk,
  input  logic                rst,
  input  logic                ifu_valid_i,
  input  logic                lsu_rvalid_i,
  input  logic                lsu_wvalid_i,
  input  logic                lsu_local_i,
  input  logic                arready_i,
  input  logic                awready_i,
  input  logic                wready_i,
  input  logic                rvalid_i,
  input  logic                bvalid_i,
  input  logic                clint_rvalid_i,
  output bus_pkg::arb_state_t state_o,
  output logic                aw_pending_o,
  output logic                w_pending_o,
  output logic                arvalid_o
);
  import bus_pkg::*;

  arb_state_t state;
  logic       aw_done;
  logic       w_done;
  logic       ls_wait;

  assign ls_wait = lsu_rvalid_i | lsu_wvalid_i;
  assign state_o = state;

  // store takes precedence inside LS_A
  // timer loads stay off the bus
  assign arvalid_o = ((state == IF_A) & ifu_valid_i) |
                     ((state == LS_A) & lsu_rvalid_i & !lsu_wvalid_i & !lsu_local_i);

  assign aw_pending_o = (state == LS_A) & lsu_wvalid_i & !aw_done;
  assign w_pending_o  = (state == LS_A) & lsu_wvalid_i & !w_done;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state   <= IF_A;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end
    else
    begin
      case (state)
        IF_A:
        begin
          if (ifu_valid_i)
          begin
            if (arready_i)
              state <= IF_D;
          end
          else if (ls_wait)
          begin
            state   <= LS_A;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
          end
        end
        IF_D:
        begin
          if (rvalid_i)
            state <= ls_wait ? LS_GAP : IF_A;
        end
        LS_GAP:
        begin
          aw_done <= 1'b0;
          w_done  <= 1'b0;
          state   <= ls_wait ? LS_A : IF_A;
        end
        LS_A:
        begin
          if (lsu_wvalid_i)
          begin
            // aw and w each go out once
            if (aw_pending_o & awready_i)
              aw_done <= 1'b1;
            if (w_pending_o & wready_i)
              w_done <= 1'b1;
            if (bvalid_i)
              state <= LS_D_W;
          end
          else if (lsu_rvalid_i)
          begin
            if (lsu_local_i | arready_i)
              state <= LS_D_R;
          end
          else
            state <= IF_A;
        end
        LS_D_R:
        begin
          if (rvalid_i | clint_rvalid_i)
            state <= IF_A;
        end
        LS_D_W:
          state <= IF_A;
        default:
          state <= IF_A;
      endcase
    end
  end

endmodule

//--- source/bus_pkg.sv
`include "bus_defines.svh"

package bus_pkg;

  typedef logic [`BUS_ADDR_W-1:0] addr_t;
  typedef logic [`BUS_DATA_W-1:0] word_t;
  typedef logic [`BUS_AXI_DATA_W-1:0] axi_data_t;
  typedef logic [`BUS_AXI_STRB_W-1:0] axi_strb_t;
  typedef logic [2:0] size_t;

  typedef enum logic [2:0] {
    IF_A,
    IF_D,
    LS_GAP,
    LS_A,
    LS_D_R,
    LS_D_W
  } arb_state_t;

  typedef struct packed {
    addr_t addr;
    logic [3:0] mask;
  } rd_req_t;

  typedef struct packed {
    addr_t addr;
    word_t data;
    logic [3:0] mask;
  } wr_req_t;

  typedef struct packed {
    addr_t addr;
    size_t size;
  } ar_chan_t;

  typedef struct packed {
    addr_t addr;
    size_t size;
  } aw_chan_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
  } w_chan_t;

  // byte, halfword or word from an unshifted mask
  function automatic size_t size_from_mask(input logic [3:0] mask);
    size_t size;
    case (mask)
      4'b0011: size = 3'd1;
      4'b1111: size = 3'd2;
      default: size = 3'd0;
    endcase
    return size;
  endfunction

endpackage

//--- source/bus_defines.svh
`ifndef BUS_DEFINES_SVH
`define BUS_DEFINES_SVH

// address and data widths
`define BUS_ADDR_W 32
`define BUS_DATA_W 32
`define BUS_AXI_DATA_W 64

// byte lanes on the master bus
`define BUS_AXI_STRB_W (`BUS_AXI_DATA_W / 8)

// mtime words answered locally
`define BUS_RTC_ADDR 32'h0200_bff8
`define BUS_RTC_ADDR_UP 32'h0200_bffc

`endif
